// File: bus_pkg.sv
package bus_pkg;

    // Widths seen on the core side of the peripheral bus
    localparam int ADDR_W = 11;
    localparam int DATA_W = 32;
    localparam int BYTE_W = 8;

    // Access size as driven by the core
    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b10,
        NONE = 2'b11   // No access this cycle
    } bus_size_e;

    // Request held stable by the core for the whole access
    typedef struct packed {
        logic [ADDR_W-1:0] addr;       // Byte address within the peripheral space
        logic [DATA_W-1:0] wdata;      // Low 8, 16 or 32 bits valid on write
        bus_size_e         write_size;
        bus_size_e         read_size;
    } bus_req_t;

    // One write enable per mapped peripheral
    typedef struct packed {
        logic gpio;
        logic scratch;
        logic pwm;
    } peri_sel_t;

endpackage

// File: periph_map_pkg.sv
package periph_map_pkg;

    // Slot counts and pin count
    localparam int NUM_SLOTS = 16;
    localparam int NUM_PINS  = 8;

    // Slot numbers of the mapped peripherals
    localparam logic [3:0] SLOT_GPIO    = 4'd1;   // User space
    localparam logic [3:0] SLOT_SCRATCH = 4'd0;   // Simple space
    localparam logic [3:0] SLOT_PWM     = 4'd5;   // Simple space, also the audio source

    // Register offsets inside the GPIO slot
    localparam logic [5:0] GPIO_OUT_OFS   = 6'h00;
    localparam logic [5:0] GPIO_IN_OFS    = 6'h04;
    localparam logic [5:0] GPIO_AUDIO_OFS = 6'h10;
    localparam logic [5:0] GPIO_FSEL_BASE = 6'h20;   // Pin i at base + 4*i

    // Output function select of one pin
    typedef struct packed {
        logic       simple;   // Set selects the simple space
        logic [3:0] slot;
    } func_sel_t;

    // All pins come out of reset driven by the GPIO register
    localparam func_sel_t FSEL_RESET = '{simple: 1'b0, slot: SLOT_GPIO};

    localparam int AUDIO_SEL_W  = 3;
    localparam int SCRATCH_REGS = 4;

endpackage

// File: periph_decode.sv
`timescale 1ns/1ps

module periph_decode (
    input  bus_pkg::bus_req_t           i_bus_req,
    input  logic                        i_masked,
    input  logic [bus_pkg::DATA_W-1:0]  i_gpio_data,
    input  logic [bus_pkg::BYTE_W-1:0]  i_scratch_data,
    input  logic [bus_pkg::BYTE_W-1:0]  i_pwm_data,
    output bus_pkg::peri_sel_t          o_sel,
    output logic [bus_pkg::DATA_W-1:0]  o_peri_data,
    output logic                        o_peri_ready,
    output logic                        o_read_req,
    output logic                        o_write_ack
);
    import bus_pkg::*;
    import periph_map_pkg::*;

    logic                         is_simple;
    logic [$clog2(NUM_SLOTS)-1:0] slot;
    logic [NUM_SLOTS-1:0]         user_hit;
    logic [NUM_SLOTS-1:0]         simple_hit;
    logic                         write_req;
    logic                         read_present;

    // Top address bit splits user and simple space
    assign is_simple = i_bus_req.addr[ADDR_W-1];
    assign slot      = is_simple ? i_bus_req.addr[7:4] : i_bus_req.addr[9:6];

    always_comb begin
        user_hit   = '0;
        simple_hit = '0;
        if (is_simple) begin
            simple_hit[slot] = 1'b1;
        end else begin
            user_hit[slot] = 1'b1;
        end
    end

    assign write_req    = (i_bus_req.write_size != NONE);
    assign read_present = (i_bus_req.read_size != NONE);

    // Any write size reaches the peripheral, which takes the low byte
    assign o_sel.gpio    = write_req && user_hit[SLOT_GPIO];
    assign o_sel.scratch = write_req && simple_hit[SLOT_SCRATCH];
    assign o_sel.pwm     = write_req && simple_hit[SLOT_PWM];

    // Writes are acknowledged at once, mapped or not
    assign o_write_ack = write_req;

    // Hold off the request while the buffered word is still on the bus
    assign o_read_req = read_present && !i_masked;

    always_comb begin
        o_peri_data = '0;   // Unmapped slots read zero
        if (user_hit[SLOT_GPIO]) begin
            o_peri_data = i_gpio_data;
        end else if (simple_hit[SLOT_SCRATCH]) begin
            o_peri_data = {{(DATA_W-BYTE_W){1'b0}}, i_scratch_data};
        end else if (simple_hit[SLOT_PWM]) begin
            o_peri_data = {{(DATA_W-BYTE_W){1'b0}}, i_pwm_data};
        end
    end

    // No slot in this map stalls a read
    assign o_peri_ready = 1'b1;

endmodule

// File: read_hold_buffer.sv
`timescale 1ns/1ps

module read_hold_buffer (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        i_read_req,
    input  logic                        i_peri_ready,
    input  logic [bus_pkg::DATA_W-1:0]  i_peri_data,
    input  logic                        i_write_ack,
    input  logic                        i_read_complete,
    output logic                        o_masked,
    output logic [bus_pkg::DATA_W-1:0]  o_data,
    output logic                        o_data_ready
);

    logic data_hold;   // Captured word not yet consumed by the core
    logic ready_r;
    logic capture;

    // Take a new word only when the previous one has been released
    assign capture = i_read_req && i_peri_ready && !data_hold;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_hold <= 1'b0;
            ready_r   <= 1'b0;
        end else begin
            ready_r <= capture;   // Ready one cycle after the request
            if (capture) begin
                data_hold <= 1'b1;
            end else if (i_read_complete) begin
                data_hold <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            o_data <= i_peri_data;
        end
    end

    assign o_masked     = ready_r;
    assign o_data_ready = ready_r || i_write_ack;   // Write ack is combinational

endmodule

// File: gpio_ctrl.sv
`timescale 1ns/1ps

module gpio_ctrl (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                i_we,
    input  logic [5:0]                          i_offset,
    input  logic [bus_pkg::BYTE_W-1:0]          i_wdata,
    input  logic [periph_map_pkg::NUM_PINS-1:0] i_pins,
    input  logic [periph_map_pkg::NUM_PINS-1:0] i_scratch_pins,
    input  logic [periph_map_pkg::NUM_PINS-1:0] i_pwm_pins,
    output logic [bus_pkg::DATA_W-1:0]          o_rdata,
    output logic [periph_map_pkg::NUM_PINS-1:0] o_pins,
    output logic                                o_audio_select
);
    import periph_map_pkg::*;

    logic [NUM_PINS-1:0]         gpio_out;
    logic [AUDIO_SEL_W-1:0]      audio_sel;
    func_sel_t                   func_sel [NUM_PINS];
    logic                        fsel_hit;
    logic [5:0]                  fsel_rel;
    logic [$clog2(NUM_PINS)-1:0] fsel_idx;

    // Function selects are word spaced from the base
    assign fsel_rel = i_offset - GPIO_FSEL_BASE;
    assign fsel_hit = (i_offset >= GPIO_FSEL_BASE) && (i_offset[1:0] == 2'b00);
    assign fsel_idx = fsel_rel[2 +: $clog2(NUM_PINS)];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out  <= '0;
            audio_sel <= '0;
            for (int i = 0; i < NUM_PINS; i++) begin
                func_sel[i] <= FSEL_RESET;
            end
        end else if (i_we) begin
            if (i_offset == GPIO_OUT_OFS) begin
                gpio_out <= i_wdata[NUM_PINS-1:0];
            end
            if (i_offset == GPIO_AUDIO_OFS) begin
                audio_sel <= i_wdata[AUDIO_SEL_W-1:0];
            end
            if (fsel_hit) begin
                func_sel[fsel_idx] <= i_wdata[$bits(func_sel_t)-1:0];
            end
        end
    end

    // Readback, zero extended
    always_comb begin
        o_rdata = '0;
        if (i_offset == GPIO_OUT_OFS) begin
            o_rdata[NUM_PINS-1:0] = gpio_out;
        end else if (i_offset == GPIO_IN_OFS) begin
            o_rdata[NUM_PINS-1:0] = i_pins;
        end else if (i_offset == GPIO_AUDIO_OFS) begin
            o_rdata[AUDIO_SEL_W-1:0] = audio_sel;
        end else if (fsel_hit) begin
            o_rdata[$bits(func_sel_t)-1:0] = func_sel[fsel_idx];
        end
    end

    // Per pin output mux, unmapped sources drive low
    always_comb begin
        for (int i = 0; i < NUM_PINS; i++) begin
            o_pins[i] = 1'b0;
            if (!func_sel[i].simple && func_sel[i].slot == SLOT_GPIO) begin
                o_pins[i] = gpio_out[i];
            end else if (func_sel[i].simple && func_sel[i].slot == SLOT_SCRATCH) begin
                o_pins[i] = i_scratch_pins[i];
            end else if (func_sel[i].simple && func_sel[i].slot == SLOT_PWM) begin
                o_pins[i] = i_pwm_pins[i];
            end
        end
    end

    assign o_audio_select = audio_sel[AUDIO_SEL_W-1];

endmodule

// File: scratch_byte_peri.sv
`timescale 1ns/1ps

module scratch_byte_peri (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                i_we,
    input  logic [3:0]                          i_offset,
    input  logic [bus_pkg::BYTE_W-1:0]          i_wdata,
    output logic [bus_pkg::BYTE_W-1:0]          o_rdata,
    output logic [periph_map_pkg::NUM_PINS-1:0] o_pins
);
    import bus_pkg::*;
    import periph_map_pkg::*;

    logic [BYTE_W-1:0]               regs [SCRATCH_REGS];
    logic [$clog2(SCRATCH_REGS)-1:0] idx;
    logic                            in_range;

    assign idx      = i_offset[$clog2(SCRATCH_REGS)-1:0];
    assign in_range = (i_offset < 4'(SCRATCH_REGS));   // Upper offsets are empty

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < SCRATCH_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && in_range) begin
            regs[idx] <= i_wdata;
        end
    end

    assign o_rdata = in_range ? regs[idx] : '0;

    // Register 0 doubles as the pin output
    assign o_pins = regs[0][NUM_PINS-1:0];

endmodule

// File: pwm_byte_peri.sv
`timescale 1ns/1ps

module pwm_byte_peri (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                i_we,
    input  logic [3:0]                          i_offset,
    input  logic [bus_pkg::BYTE_W-1:0]          i_wdata,
    output logic [bus_pkg::BYTE_W-1:0]          o_rdata,
    output logic [periph_map_pkg::NUM_PINS-1:0] o_pins
);
    import bus_pkg::*;
    import periph_map_pkg::*;

    logic [BYTE_W-1:0] duty;
    logic [BYTE_W-1:0] counter;   // Wraps every 256 cycles
    logic              level;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            duty    <= '0;
            counter <= '0;
            level   <= 1'b0;
        end else begin
            counter <= counter + 1'b1;
            level   <= (counter < duty);   // High for duty counts per period
            if (i_we && i_offset == 4'h0) begin
                duty <= i_wdata;
            end
        end
    end

    // Only the duty register is visible
    assign o_rdata = (i_offset == 4'h0) ? duty : '0;

    assign o_pins = {NUM_PINS{level}};

endmodule

// File: periph_top.sv
`timescale 1ns/1ps

module periph_top (
    input  logic                                clk,
    input  logic                                rst_n,
    input  bus_pkg::bus_req_t                   i_bus_req,
    input  logic                                i_read_complete,
    input  logic [periph_map_pkg::NUM_PINS-1:0] i_pins,
    output logic [periph_map_pkg::NUM_PINS-1:0] o_pins,
    output logic                                o_audio,
    output logic                                o_audio_select,
    output logic [bus_pkg::DATA_W-1:0]          o_data,
    output logic                                o_data_ready
);
    import bus_pkg::*;
    import periph_map_pkg::*;

    peri_sel_t           sel;
    logic [DATA_W-1:0]   gpio_data;
    logic [DATA_W-1:0]   peri_data;
    logic [BYTE_W-1:0]   scratch_data;
    logic [BYTE_W-1:0]   pwm_data;
    logic [NUM_PINS-1:0] scratch_pins;
    logic [NUM_PINS-1:0] pwm_pins;
    logic                peri_ready;
    logic                read_req;
    logic                write_ack;
    logic                masked;

    periph_decode u_decode (
        .i_bus_req      (i_bus_req),
        .i_masked       (masked),
        .i_gpio_data    (gpio_data),
        .i_scratch_data (scratch_data),
        .i_pwm_data     (pwm_data),
        .o_sel          (sel),
        .o_peri_data    (peri_data),
        .o_peri_ready   (peri_ready),
        .o_read_req     (read_req),
        .o_write_ack    (write_ack)
    );

    read_hold_buffer u_hold (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_read_req      (read_req),
        .i_peri_ready    (peri_ready),
        .i_peri_data     (peri_data),
        .i_write_ack     (write_ack),
        .i_read_complete (i_read_complete),
        .o_masked        (masked),
        .o_data          (o_data),
        .o_data_ready    (o_data_ready)
    );

    // User slot, 6 bit offset
    gpio_ctrl u_gpio (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_we           (sel.gpio),
        .i_offset       (i_bus_req.addr[5:0]),
        .i_wdata        (i_bus_req.wdata[BYTE_W-1:0]),
        .i_pins         (i_pins),
        .i_scratch_pins (scratch_pins),
        .i_pwm_pins     (pwm_pins),
        .o_rdata        (gpio_data),
        .o_pins         (o_pins),
        .o_audio_select (o_audio_select)
    );

    // Simple slots, 4 bit offset and byte data
    scratch_byte_peri u_scratch (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_we     (sel.scratch),
        .i_offset (i_bus_req.addr[3:0]),
        .i_wdata  (i_bus_req.wdata[BYTE_W-1:0]),
        .o_rdata  (scratch_data),
        .o_pins   (scratch_pins)
    );

    pwm_byte_peri u_pwm (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_we     (sel.pwm),
        .i_offset (i_bus_req.addr[3:0]),
        .i_wdata  (i_bus_req.wdata[BYTE_W-1:0]),
        .o_rdata  (pwm_data),
        .o_pins   (pwm_pins)
    );

    assign o_audio = pwm_pins[NUM_PINS-1];   // Audio taken from PWM bit 7

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic o_clk
);
    localparam realtime HALF_PERIOD = 50ns;   // 100 ns clock

    initial begin
        o_clk = 1'b0;
        forever #(HALF_PERIOD) o_clk = ~o_clk;
    end

endmodule

// File: periph_top_asserts.sv
`timescale 1ns/1ps

module periph_top_asserts (
    input logic                       clk,
    input logic                       rst_n,
    input logic                       i_read_req,
    input logic                       i_peri_ready,
    input logic                       i_read_complete,
    input logic                       i_ready,
    input logic [bus_pkg::DATA_W-1:0] i_data
);

    logic pending;   // Word presented to the core and not yet released

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending <= 1'b0;
        end else if (i_read_complete) begin
            pending <= 1'b0;
        end else if (i_ready) begin
            pending <= 1'b1;
        end
    end

    // Held word stays put until the core releases it
    a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (i_ready || pending) |=> $stable(i_data))
        else $error("Read data changed while held");

    // A request with no word outstanding is answered next cycle
    a_ready_latency: assert property (@(posedge clk) disable iff (!rst_n)
        (i_read_req && i_peri_ready && !i_ready && !pending) |=> i_ready)
        else $error("Ready did not follow an accepted read by one cycle");

    a_reset_ready: assert property (@(posedge clk) !rst_n |=> !i_ready)
        else $error("Ready high after reset");

endmodule

bind read_hold_buffer periph_top_asserts u_asserts (
    .clk             (clk),
    .rst_n           (rst_n),
    .i_read_req      (i_read_req),
    .i_peri_ready    (i_peri_ready),
    .i_read_complete (i_read_complete),
    .i_ready         (ready_r),
    .i_data          (o_data)
);

// File: periph_top_tb.sv
`timescale 1ns/1ps

module periph_top_tb;
    import bus_pkg::*;
    import periph_map_pkg::*;

    localparam int TEST_CYCLES    = 1500;                    // Rough length of all tests
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES + 200;

    logic clk, rst_n, read_complete, audio, audio_select, data_ready;
    bus_req_t            req;
    logic [NUM_PINS-1:0] pins_in, pins_out;
    logic [DATA_W-1:0]   rdata, cmp_act, cmp_exp, data;
    logic [ADDR_W-1:0]   addr;
    logic [3:0]          slot;
    logic [7:0]          duty;
    logic [7:0]          m_scratch [SCRATCH_REGS];   // Register model
    logic [7:0]          m_gpio_out, m_duty, m_cnt;
    logic [2:0]          m_audio_sel;
    logic                m_level;
    func_sel_t           m_fsel [NUM_PINS];
    logic [DATA_W-1:0]   act_q [$], exp_q [$];
    logic [4:0]          sources [5] = '{{1'b0, SLOT_GPIO}, {1'b1, SLOT_SCRATCH},
                                         {1'b1, SLOT_PWM}, 5'h03, 5'h1c};
    int     errors = 0, checks = 0, tests = 0, mark = 0, high;
    integer seed = 32951;

    tb_clock_gen u_clk (.o_clk(clk));

    periph_top dut0 (
        .clk(clk), .rst_n(rst_n), .i_bus_req(req), .i_read_complete(read_complete),
        .i_pins(pins_in), .o_pins(pins_out), .o_audio(audio), .o_audio_select(audio_select),
        .o_data(rdata), .o_data_ready(data_ready)
    );

    function automatic logic [ADDR_W-1:0] user_addr(input logic [3:0] s, input logic [5:0] o);
        return {1'b0, s, o};
    endfunction

    function automatic logic [ADDR_W-1:0] simple_addr(input logic [3:0] s, input logic [3:0] o);
        return {1'b1, 2'b00, s, o};
    endfunction

    function automatic logic [DATA_W-1:0] expected_read(input logic [ADDR_W-1:0] a);
        logic [3:0] s;
        logic [5:0] o;
        s = a[10] ? a[7:4] : a[9:6];
        o = a[10] ? {2'b00, a[3:0]} : a[5:0];
        if (a[10] && s == SLOT_SCRATCH && o < SCRATCH_REGS) return 32'(m_scratch[o[1:0]]);
        if (a[10] && s == SLOT_PWM && o == 6'h00) return 32'(m_duty);
        if (a[10] || s != SLOT_GPIO) return '0;   // Unmapped slots read zero
        if (o == GPIO_OUT_OFS) return 32'(m_gpio_out);
        if (o == GPIO_IN_OFS) return 32'(pins_in);
        if (o == GPIO_AUDIO_OFS) return 32'(m_audio_sel);
        if (o >= GPIO_FSEL_BASE && o[1:0] == 2'b00) return 32'(m_fsel[o[4:2]]);
        return '0;
    endfunction

    function automatic void model_write(input logic [ADDR_W-1:0] a, input logic [7:0] d);
        logic [3:0] s;
        logic [5:0] o;
        s = a[10] ? a[7:4] : a[9:6];
        o = a[10] ? {2'b00, a[3:0]} : a[5:0];
        if (a[10] && s == SLOT_SCRATCH && o < SCRATCH_REGS) m_scratch[o[1:0]] = d;
        if (a[10] && s == SLOT_PWM && o == 6'h00) m_duty = d;
        if (!a[10] && s == SLOT_GPIO && o == GPIO_OUT_OFS) m_gpio_out = d;
        if (!a[10] && s == SLOT_GPIO && o == GPIO_AUDIO_OFS) m_audio_sel = d[2:0];
        if (!a[10] && s == SLOT_GPIO && o >= GPIO_FSEL_BASE && o[1:0] == 2'b00)
            m_fsel[o[4:2]] = d[4:0];
    endfunction

    function automatic logic [NUM_PINS-1:0] expected_pins();
        logic [NUM_PINS-1:0] p;
        for (int i = 0; i < NUM_PINS; i++) begin
            case ({m_fsel[i].simple, m_fsel[i].slot})
                {1'b0, SLOT_GPIO}:    p[i] = m_gpio_out[i];
                {1'b1, SLOT_SCRATCH}: p[i] = m_scratch[0][i];
                {1'b1, SLOT_PWM}:     p[i] = m_level;
                default:              p[i] = 1'b0;
            endcase
        end
        return p;
    endfunction

    task automatic record_failure(input string msg);
        $display("%s", msg);
        errors++;
    endtask

    // PWM level model, counter free runs from reset
    always @(posedge clk) begin
        if (!rst_n) begin
            m_cnt   = '0;
            m_level = 1'b0;
        end else begin
            m_level = (m_cnt < m_duty);
            m_cnt   = m_cnt + 8'd1;
        end
    end

    task automatic write_reg(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
        @(negedge clk);
        req = '{addr: a, wdata: d, write_size: bus_size_e'(2'($unsigned($random(seed)) % 3)),
                read_size: NONE};
        #1 checks++;
        assert (data_ready) else record_failure($sformatf("Write to %h was not acknowledged", a));
        @(negedge clk);
        req.write_size = NONE;
        model_write(a, d[7:0]);
    endtask

    // Core side read with an optional delay before read complete
    task automatic read_reg(input logic [ADDR_W-1:0] a, input int delay);
        int          waited;
        logic [31:0] held;
        @(negedge clk);
        req.addr      = a;
        req.read_size = WORD;
        waited        = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!data_ready && waited < 4);
        checks++;
        assert (data_ready && waited == 1)
        else record_failure($sformatf("Read of %h was not ready one cycle after request", a));
        held = rdata;
        act_q.push_back(held);
        exp_q.push_back(expected_read(a));
        repeat (delay) begin
            pins_in = ~pins_in;   // Input pins move under the held word
            @(negedge clk);
            checks++;
            assert (rdata === held && !data_ready) else record_failure($sformatf(
                "CHECK FAILED at %0t: held read of %h changed or recaptured", $time, a));
        end
        read_complete = 1'b1;
        @(negedge clk);
        read_complete = 1'b0;
        req.read_size = NONE;
    endtask

    task automatic check_pins();
        checks++;
        assert (pins_out === expected_pins()) else record_failure($sformatf(
            "CHECK FAILED at %0t: pins %b, expected %b", $time, pins_out, expected_pins()));
    endtask

    task automatic report_test(input string name);
        repeat (2) @(negedge clk);   // Let queued reads be compared
        tests++;
        $display("%-10s %s, %0d errors", name, (errors == mark) ? "ok" : "failed", errors - mark);
        mark = errors;
    endtask

    always @(negedge clk) begin
        while (act_q.size() > 0) begin
            cmp_act = act_q.pop_front();
            cmp_exp = exp_q.pop_front();
            checks++;
            assert (cmp_act === cmp_exp) else record_failure($sformatf(
                "CHECK FAILED at %0t: read %h, expected %h", $time, cmp_act, cmp_exp));
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * 100);
        $display("Timeout: tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        req = '{addr: '0, wdata: '0, write_size: NONE, read_size: NONE};
        read_complete = 1'b0;
        pins_in       = 8'h00;
        rst_n         = 1'b0;
        m_gpio_out    = '0;
        m_duty        = '0;
        m_audio_sel   = '0;
        for (int i = 0; i < NUM_PINS; i++) m_fsel[i] = FSEL_RESET;
        for (int i = 0; i < SCRATCH_REGS; i++) m_scratch[i] = '0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        checks++;
        assert (!data_ready && !audio_select && !audio && pins_out === 8'h00)
        else record_failure($sformatf(
            "CHECK FAILED at %0t: outputs not in their reset state after reset", $time));
        write_reg(user_addr(SLOT_GPIO, GPIO_OUT_OFS), $random(seed));
        check_pins();   // Pins start on the GPIO function
        report_test("reset");
        repeat (24) begin
            addr = simple_addr(SLOT_SCRATCH, 4'($random(seed)));
            write_reg(addr, $random(seed));
            read_reg(addr, 0);
        end
        report_test("scratch");
        pins_in = 8'($random(seed));
        write_reg(user_addr(SLOT_GPIO, GPIO_OUT_OFS), $random(seed));
        read_reg(user_addr(SLOT_GPIO, GPIO_OUT_OFS), 0);
        read_reg(user_addr(SLOT_GPIO, GPIO_IN_OFS), 0);
        repeat (4) begin
            data = $random(seed);
            write_reg(user_addr(SLOT_GPIO, GPIO_AUDIO_OFS), data);
            read_reg(user_addr(SLOT_GPIO, GPIO_AUDIO_OFS), 0);
            checks++;
            assert (audio_select === data[2]) else record_failure($sformatf(
                "CHECK FAILED at %0t: audio select %b, expected %b", $time, audio_select, data[2]));
        end
        for (int i = 0; i < NUM_PINS; i++) begin
            addr = user_addr(SLOT_GPIO, GPIO_FSEL_BASE + 6'(4 * i));
            write_reg(addr, $random(seed));
            read_reg(addr, 0);
        end
        read_reg(user_addr(SLOT_GPIO, 6'h08), 0);
        read_reg(user_addr(SLOT_GPIO, 6'h22), 0);
        report_test("gpio");
        write_reg(simple_addr(SLOT_SCRATCH, 4'h0), $random(seed));
        write_reg(simple_addr(SLOT_PWM, 4'h0), 32'd128);   // Level toggles every 128 cycles
        repeat (6) begin
            for (int i = 0; i < NUM_PINS; i++) begin
                write_reg(user_addr(SLOT_GPIO, GPIO_FSEL_BASE + 6'(4 * i)),
                          32'(sources[$unsigned($random(seed)) % 5]));
                check_pins();
            end
        end
        report_test("pin mux");
        for (int k = 0; k < 3; k++) begin
            duty = (k == 0) ? 8'd0 : (k == 1) ? 8'($random(seed)) : 8'hff;
            write_reg(simple_addr(SLOT_PWM, 4'h0), 32'(duty));
            read_reg(simple_addr(SLOT_PWM, 4'h0), 0);
            read_reg(simple_addr(SLOT_PWM, 4'h3), 0);
            high = 0;
            repeat (256) begin
                @(negedge clk);
                high += audio;
            end
            checks++;
            assert (high == duty) else record_failure($sformatf(
                "CHECK FAILED at %0t: audio high %0d of 256 cycles, duty %0d", $time, high, duty));
        end
        report_test("pwm");
        repeat (8) begin
            slot = 4'($random(seed));
            read_reg(user_addr((slot == SLOT_GPIO) ? 4'd2 : slot, 6'($random(seed))), 0);
            slot = 4'($random(seed));
            if (slot == SLOT_SCRATCH || slot == SLOT_PWM) slot = 4'd9;
            read_reg(simple_addr(slot, 4'($random(seed))), 0);
        end
        repeat (8) begin
            pins_in = 8'($random(seed));
            // Core holds off read complete
            read_reg(user_addr(SLOT_GPIO, GPIO_IN_OFS), 1 + $unsigned($random(seed)) % 8);
        end
        report_test("unmapped");
        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: periph_top.f
bus_pkg.sv
periph_map_pkg.sv
periph_decode.sv
read_hold_buffer.sv
gpio_ctrl.sv
scratch_byte_peri.sv
pwm_byte_peri.sv
periph_top.sv
tb_clock_gen.sv
periph_top_asserts.sv
periph_top_tb.sv
